// ==== rtl/cart_mem_ctrl.sv ====
`timescale 1ns/1ns
module cart_mem_ctrl
  import snes_bus_pkg::*;
  import mem_pkg::*;
#(
  parameter cycle_len_t ROM_CYCLE_LEN_RESET = 4'd7,
  parameter cycle_len_t RAM_CYCLE_LEN_RESET = 4'd5
) (
  input  logic       CLK2,
  input  logic       SNES_reset_strobe,
  input  logic       snes_cpu_clk,
  input  logic       is_rom,
  input  logic       is_saveram,
  input  snes_addr_t snes_addr,
  // MCU channel
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  byte_t      mcu_wdata,
  output logic       mcu_rdy,
  output byte_t      mcu_rdata,
  // SA1 channels
  input  logic       sa1_rom_rrq,
  input  snes_addr_t sa1_rom_addr,
  input  logic       sa1_rom_word,
  output logic       sa1_rom_rdy,
  output word_t      sa1_rom_rdata,
  input  logic       sa1_ram_rrq,
  input  logic       sa1_ram_wrq,
  input  snes_addr_t sa1_ram_addr,
  input  byte_t      sa1_ram_wdata,
  output logic       sa1_ram_rdy,
  output byte_t      sa1_ram_rdata,
  // configuration strobe
  input  logic       cfg_we,
  input  byte_t      cfg_group,
  input  byte_t      cfg_index,
  input  byte_t      cfg_value,
  input  byte_t      cfg_invmask,
  // PSRAM
  output rom_addr_t  rom_addr,
  input  word_t      rom_rdata,
  output word_t      rom_wdata,
  output logic       rom_we,
  output logic       rom_bhe,
  output logic       rom_ble,
  // SRAM
  output ram_addr_t  ram_addr,
  input  byte_t      ram_rdata,
  output byte_t      ram_wdata,
  output logic       ram_we
);

  logic       rom_free_slot;
  logic       ram_free_slot;
  cycle_len_t rom_cycle_len;
  cycle_len_t ram_cycle_len;
  logic       mcu_rom_rd_pend;
  logic       mcu_rom_wr_pend;
  logic       mcu_ram_rd_pend;
  logic       mcu_ram_wr_pend;
  snes_addr_t mcu_req_addr;
  byte_t      mcu_req_wdata;
  logic       rom_mcu_done;
  logic       ram_mcu_done;
  byte_t      rom_mcu_rdata;
  byte_t      ram_mcu_rdata;

  snes_slot_timer u_slot (
    .CLK2,
    .SNES_reset_strobe,
    .snes_cpu_clk,
    .is_rom,
    .is_saveram,
    .rom_free_slot,
    .ram_free_slot
  );

  mem_config_regs #(
    .ROM_CYCLE_LEN_RESET(ROM_CYCLE_LEN_RESET),
    .RAM_CYCLE_LEN_RESET(RAM_CYCLE_LEN_RESET)
  ) u_cfg (
    .CLK2,
    .SNES_reset_strobe,
    .cfg_we,
    .cfg_group,
    .cfg_index,
    .cfg_value,
    .cfg_invmask,
    .rom_cycle_len,
    .ram_cycle_len
  );

  mcu_request_router u_mcu (
    .CLK2,
    .SNES_reset_strobe,
    .mcu_rrq,
    .mcu_wrq,
    .mcu_addr,
    .mcu_wdata,
    .mcu_rdy,
    .mcu_rdata,
    .mcu_rom_rd_pend,
    .mcu_rom_wr_pend,
    .mcu_ram_rd_pend,
    .mcu_ram_wr_pend,
    .mcu_req_addr,
    .mcu_req_wdata,
    .rom_mcu_done,
    .ram_mcu_done,
    .rom_mcu_rdata,
    .ram_mcu_rdata
  );

  rom_arbiter u_rom (
    .CLK2,
    .SNES_reset_strobe,
    .rom_free_slot,
    .rom_cycle_len,
    .mcu_rom_rd_pend,
    .mcu_rom_wr_pend,
    .mcu_req_addr,
    .mcu_req_wdata,
    .rom_mcu_done,
    .rom_mcu_rdata,
    .sa1_rom_rrq,
    .sa1_rom_addr,
    .sa1_rom_word,
    .sa1_rom_rdy,
    .sa1_rom_rdata,
    .snes_addr,
    .rom_addr,
    .rom_rdata,
    .rom_wdata,
    .rom_we,
    .rom_bhe,
    .rom_ble
  );

  ram_arbiter u_ram (
    .CLK2,
    .SNES_reset_strobe,
    .ram_free_slot,
    .ram_cycle_len,
    .mcu_ram_rd_pend,
    .mcu_ram_wr_pend,
    .mcu_req_addr,
    .mcu_req_wdata,
    .ram_mcu_done,
    .ram_mcu_rdata,
    .sa1_ram_rrq,
    .sa1_ram_wrq,
    .sa1_ram_addr,
    .sa1_ram_wdata,
    .sa1_ram_rdy,
    .sa1_ram_rdata,
    .snes_addr,
    .ram_addr,
    .ram_rdata,
    .ram_wdata,
    .ram_we
  );

endmodule

// ==== rtl/mcu_request_router.sv ====
`timescale 1ns/1ns
module mcu_request_router
  import snes_bus_pkg::*;
  import mem_pkg::*;
(
  input  logic       CLK2,
  input  logic       SNES_reset_strobe,
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  byte_t      mcu_wdata,
  output logic       mcu_rdy,
  output byte_t      mcu_rdata,
  output logic       mcu_rom_rd_pend,
  output logic       mcu_rom_wr_pend,
  output logic       mcu_ram_rd_pend,
  output logic       mcu_ram_wr_pend,
  output snes_addr_t mcu_req_addr,
  output byte_t      mcu_req_wdata,
  input  logic       rom_mcu_done,
  input  logic       ram_mcu_done,
  input  byte_t      rom_mcu_rdata,
  input  byte_t      ram_mcu_rdata
);

  logic in_ram_bank;
  logic rom_req;
  logic ram_req;
  logic rom_rdy_half;
  logic ram_rdy_half;

  assign in_ram_bank = (mcu_addr[23:19] == MCU_RAM_BANK);
  assign rom_req     = (mcu_rrq || mcu_wrq) && !in_ram_bank;
  assign ram_req     = (mcu_rrq || mcu_wrq) && in_ram_bank;

  // --------------------------------------------------
  // pending flags and ready halves
  // --------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      mcu_rom_rd_pend <= 1'b0;
      mcu_rom_wr_pend <= 1'b0;
      rom_rdy_half    <= 1'b1;
      mcu_ram_rd_pend <= 1'b0;
      mcu_ram_wr_pend <= 1'b0;
      ram_rdy_half    <= 1'b1;
    end else begin
      // a new request wins over a finishing one
      if (rom_req) begin
        mcu_rom_rd_pend <= mcu_rrq;
        mcu_rom_wr_pend <= !mcu_rrq;
        rom_rdy_half    <= 1'b0;
      end else if (rom_mcu_done) begin
        mcu_rom_rd_pend <= 1'b0;
        mcu_rom_wr_pend <= 1'b0;
        rom_rdy_half    <= 1'b1;
      end
      if (ram_req) begin
        mcu_ram_rd_pend <= mcu_rrq;
        mcu_ram_wr_pend <= !mcu_rrq;
        ram_rdy_half    <= 1'b0;
      end else if (ram_mcu_done) begin
        mcu_ram_rd_pend <= 1'b0;
        mcu_ram_wr_pend <= 1'b0;
        ram_rdy_half    <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // request payload and read data
  // --------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (rom_req || ram_req) begin
      mcu_req_addr  <= mcu_addr;
      mcu_req_wdata <= mcu_wdata;
    end
    // take the byte from whichever memory served the read
    if (rom_mcu_done && mcu_rom_rd_pend) begin
      mcu_rdata <= rom_mcu_rdata;
    end else if (ram_mcu_done && mcu_ram_rd_pend) begin
      mcu_rdata <= ram_mcu_rdata;
    end
  end

  assign mcu_rdy = rom_rdy_half && ram_rdy_half;

endmodule

// ==== rtl/mem_config_regs.sv ====
`timescale 1ns/1ns
module mem_config_regs
  import mem_pkg::*;
#(
  parameter cycle_len_t ROM_CYCLE_LEN_RESET = 4'd7,
  parameter cycle_len_t RAM_CYCLE_LEN_RESET = 4'd5
) (
  input  logic       CLK2,
  input  logic       SNES_reset_strobe,
  input  logic       cfg_we,
  input  byte_t      cfg_group,
  input  byte_t      cfg_index,
  input  byte_t      cfg_value,
  input  byte_t      cfg_invmask,
  output cycle_len_t rom_cycle_len,
  output cycle_len_t ram_cycle_len
);

  logic cfg_mem_hit;

  // invmask bits set to 1 keep the old value
  function automatic byte_t merge_masked(byte_t old_val, byte_t new_val, byte_t invmask);
    return (old_val & invmask) | (new_val & ~invmask);
  endfunction

  assign cfg_mem_hit = cfg_we && (cfg_group == CFG_GROUP_MEM);

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      rom_cycle_len <= ROM_CYCLE_LEN_RESET;
      ram_cycle_len <= RAM_CYCLE_LEN_RESET;
    end else if (cfg_mem_hit) begin
      if (cfg_index == CFG_IDX_ROM_LEN) begin
        rom_cycle_len <= cycle_len_t'(merge_masked(byte_t'(rom_cycle_len), cfg_value,
                                                   cfg_invmask));
      end
      if (cfg_index == CFG_IDX_RAM_LEN) begin
        ram_cycle_len <= cycle_len_t'(merge_masked(byte_t'(ram_cycle_len), cfg_value,
                                                   cfg_invmask));
      end
    end
  end

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  // PSRAM is word addressed
  typedef logic [22:0] rom_addr_t;
  typedef logic [18:0] ram_addr_t;

  typedef logic [3:0] cycle_len_t;

  typedef enum logic [2:0] {
    ROM_IDLE,
    ROM_MCU_RD,
    ROM_MCU_WR,
    ROM_SA1_RD,
    ROM_END
  } rom_state_e;

  typedef enum logic [2:0] {
    RAM_IDLE,
    RAM_MCU_RD,
    RAM_MCU_WR,
    RAM_SA1_RD,
    RAM_SA1_WR,
    RAM_END
  } ram_state_e;

  // banks E0-E7 hold save RAM for the MCU
  localparam logic [4:0] MCU_RAM_BANK = 5'b11100;

  // configuration strobe codes
  localparam byte_t CFG_GROUP_MEM   = 8'h02;
  localparam byte_t CFG_IDX_ROM_LEN = 8'h00;
  localparam byte_t CFG_IDX_RAM_LEN = 8'h01;

endpackage

// ==== rtl/ram_arbiter.sv ====
`timescale 1ns/1ns
module ram_arbiter
  import snes_bus_pkg::*;
  import mem_pkg::*;
(
  input  logic       CLK2,
  input  logic       SNES_reset_strobe,
  input  logic       ram_free_slot,
  input  cycle_len_t ram_cycle_len,
  input  logic       mcu_ram_rd_pend,
  input  logic       mcu_ram_wr_pend,
  input  snes_addr_t mcu_req_addr,
  input  byte_t      mcu_req_wdata,
  output logic       ram_mcu_done,
  output byte_t      ram_mcu_rdata,
  input  logic       sa1_ram_rrq,
  input  logic       sa1_ram_wrq,
  input  snes_addr_t sa1_ram_addr,
  input  byte_t      sa1_ram_wdata,
  output logic       sa1_ram_rdy,
  output byte_t      sa1_ram_rdata,
  input  snes_addr_t snes_addr,
  output ram_addr_t  ram_addr,
  input  byte_t      ram_rdata,
  output byte_t      ram_wdata,
  output logic       ram_we
);

  ram_state_e state;
  ram_state_e grant_state;
  cycle_len_t delay;
  logic       serving_sa1;
  logic       sa1_rd_pend;
  logic       sa1_wr_pend;
  snes_addr_t sa1_addr_q;
  byte_t      sa1_wdata_q;
  logic       sa1_end;
  logic       sa1_hit;
  logic       mcu_hit;

  // --------------------------------------------------
  // SA1 request latch
  // --------------------------------------------------
  assign sa1_end = (state == RAM_END) && serving_sa1;

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      sa1_rd_pend <= 1'b0;
      sa1_wr_pend <= 1'b0;
      sa1_ram_rdy <= 1'b1;
    end else if (sa1_ram_rrq || sa1_ram_wrq) begin
      sa1_rd_pend <= sa1_ram_rrq;
      sa1_wr_pend <= !sa1_ram_rrq;
      sa1_ram_rdy <= 1'b0;
    end else if (sa1_end) begin
      sa1_rd_pend <= 1'b0;
      sa1_wr_pend <= 1'b0;
      sa1_ram_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (sa1_ram_rrq || sa1_ram_wrq) begin
      sa1_addr_q  <= sa1_ram_addr;
      sa1_wdata_q <= sa1_ram_wdata;
    end
  end

  // --------------------------------------------------
  // access FSM
  // --------------------------------------------------
  always_comb begin
    grant_state = RAM_IDLE;
    if (sa1_ram_rrq || sa1_rd_pend) begin
      grant_state = RAM_SA1_RD;
    end else if (sa1_ram_wrq || sa1_wr_pend) begin
      grant_state = RAM_SA1_WR;
    end else if (mcu_ram_rd_pend) begin
      grant_state = RAM_MCU_RD;
    end else if (mcu_ram_wr_pend) begin
      grant_state = RAM_MCU_WR;
    end
  end

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state       <= RAM_IDLE;
      delay       <= '0;
      serving_sa1 <= 1'b0;
    end else begin
      case (state)
        RAM_IDLE: begin
          if (ram_free_slot && grant_state != RAM_IDLE) begin
            state       <= grant_state;
            delay       <= ram_cycle_len;
            serving_sa1 <= (grant_state == RAM_SA1_RD) || (grant_state == RAM_SA1_WR);
          end
        end
        RAM_MCU_RD, RAM_MCU_WR, RAM_SA1_RD, RAM_SA1_WR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= RAM_END;
          end
        end
        default: state <= RAM_IDLE;
      endcase
    end
  end

  assign ram_mcu_done = (state == RAM_END) && !serving_sa1;

  // --------------------------------------------------
  // address and data
  // --------------------------------------------------
  assign sa1_hit = (state == RAM_SA1_RD) || (state == RAM_SA1_WR);
  assign mcu_hit = (state == RAM_MCU_RD) || (state == RAM_MCU_WR);

  assign ram_addr = sa1_hit ? sa1_addr_q[18:0]
                  : mcu_hit ? mcu_req_addr[18:0]
                  :           snes_addr[18:0];

  assign ram_wdata = (state == RAM_SA1_WR) ? sa1_wdata_q : mcu_req_wdata;
  assign ram_we    = !((state == RAM_SA1_WR) || (state == RAM_MCU_WR));

  always_ff @(posedge CLK2) begin
    if (state == RAM_MCU_RD) begin
      ram_mcu_rdata <= ram_rdata;
    end
    if (state == RAM_SA1_RD) begin
      sa1_ram_rdata <= ram_rdata;
    end
  end

endmodule

// ==== rtl/rom_arbiter.sv ====
`timescale 1ns/1ns
module rom_arbiter
  import snes_bus_pkg::*;
  import mem_pkg::*;
(
  input  logic       CLK2,
  input  logic       SNES_reset_strobe,
  input  logic       rom_free_slot,
  input  cycle_len_t rom_cycle_len,
  input  logic       mcu_rom_rd_pend,
  input  logic       mcu_rom_wr_pend,
  input  snes_addr_t mcu_req_addr,
  input  byte_t      mcu_req_wdata,
  output logic       rom_mcu_done,
  output byte_t      rom_mcu_rdata,
  input  logic       sa1_rom_rrq,
  input  snes_addr_t sa1_rom_addr,
  input  logic       sa1_rom_word,
  output logic       sa1_rom_rdy,
  output word_t      sa1_rom_rdata,
  input  snes_addr_t snes_addr,
  output rom_addr_t  rom_addr,
  input  word_t      rom_rdata,
  output word_t      rom_wdata,
  output logic       rom_we,
  output logic       rom_bhe,
  output logic       rom_ble
);

  rom_state_e state;
  rom_state_e grant_state;
  cycle_len_t delay;
  logic       serving_sa1;
  logic       sa1_rd_pend;
  snes_addr_t sa1_addr_q;
  logic       sa1_word_q;
  logic       sa1_end;
  logic       mcu_hit;
  logic       sa1_word_hit;
  snes_addr_t sel_addr;

  // --------------------------------------------------
  // SA1 request latch
  // --------------------------------------------------
  assign sa1_end = (state == ROM_END) && serving_sa1;

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      sa1_rd_pend <= 1'b0;
      sa1_rom_rdy <= 1'b1;
    end else if (sa1_rom_rrq) begin
      sa1_rd_pend <= 1'b1;
      sa1_rom_rdy <= 1'b0;
    end else if (sa1_end) begin
      sa1_rd_pend <= 1'b0;
      sa1_rom_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (sa1_rom_rrq) begin
      sa1_addr_q <= sa1_rom_addr;
      sa1_word_q <= sa1_rom_word;
    end
  end

  // --------------------------------------------------
  // access FSM
  // --------------------------------------------------
  // SA1 pulse is granted without waiting for the latch
  always_comb begin
    grant_state = ROM_IDLE;
    if (sa1_rom_rrq || sa1_rd_pend) begin
      grant_state = ROM_SA1_RD;
    end else if (mcu_rom_rd_pend) begin
      grant_state = ROM_MCU_RD;
    end else if (mcu_rom_wr_pend) begin
      grant_state = ROM_MCU_WR;
    end
  end

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state       <= ROM_IDLE;
      delay       <= '0;
      serving_sa1 <= 1'b0;
    end else begin
      case (state)
        ROM_IDLE: begin
          if (rom_free_slot && grant_state != ROM_IDLE) begin
            state       <= grant_state;
            delay       <= rom_cycle_len;
            serving_sa1 <= (grant_state == ROM_SA1_RD);
          end
        end
        ROM_MCU_RD, ROM_MCU_WR, ROM_SA1_RD: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= ROM_END;
          end
        end
        default: state <= ROM_IDLE;
      endcase
    end
  end

  assign rom_mcu_done = (state == ROM_END) && !serving_sa1;

  // --------------------------------------------------
  // address, lanes and data
  // --------------------------------------------------
  assign mcu_hit      = (state == ROM_MCU_RD) || (state == ROM_MCU_WR);
  assign sa1_word_hit = (state == ROM_SA1_RD) && sa1_word_q;

  // SNES owns the bus unless an arbiter access is running
  assign sel_addr = (state == ROM_SA1_RD) ? sa1_addr_q
                  : mcu_hit               ? mcu_req_addr
                  :                         snes_addr;

  assign rom_addr  = sel_addr[23:1];
  assign rom_wdata = {mcu_req_wdata, mcu_req_wdata};
  assign rom_we    = (state != ROM_MCU_WR);

  // odd bytes on the low lane, even on the high lane
  assign rom_bhe = sel_addr[0] && !sa1_word_hit;
  assign rom_ble = !sel_addr[0] && !sa1_word_hit;

  always_ff @(posedge CLK2) begin
    if (state == ROM_MCU_RD) begin
      rom_mcu_rdata <= sel_addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];
    end
    if (state == ROM_SA1_RD) begin
      sa1_rom_rdata <= sel_addr[0] ? rom_rdata : {rom_rdata[7:0], rom_rdata[15:8]};
    end
  end

endmodule

// ==== rtl/snes_bus_pkg.sv ====
package snes_bus_pkg;

  // full 24-bit SNES / MCU address
  typedef logic [23:0] snes_addr_t;

  // depth of the sampled CPU clock history
  localparam int CPU_CLK_SYNC_W = 8;

endpackage

// ==== rtl/snes_slot_timer.sv ====
`timescale 1ns/1ns
module snes_slot_timer
  import snes_bus_pkg::*;
(
  input  logic CLK2,
  input  logic SNES_reset_strobe,
  input  logic snes_cpu_clk,
  input  logic is_rom,
  input  logic is_saveram,
  output logic rom_free_slot,
  output logic ram_free_slot
);

  logic [CPU_CLK_SYNC_W-1:0] cpu_clk_hist;
  logic                      cycle_end;

  // bit 0 acts as the synchronizer stage
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      cpu_clk_hist <= '1;
    end else begin
      cpu_clk_hist <= {cpu_clk_hist[CPU_CLK_SYNC_W-2:0], snes_cpu_clk};
    end
  end

  // high, then low for two samples
  assign cycle_end = (cpu_clk_hist[3:1] == 3'b100);

  // memory not addressed by the SNES is always free
  assign rom_free_slot = !is_rom || cycle_end;
  assign ram_free_slot = !is_saveram || cycle_end;

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f sources.f --top-module cart_mem_ctrl_tb \
  -Mdir obj_dir -o sim_cart_mem_ctrl \
  && ./obj_dir/sim_cart_mem_ctrl > sim.log 2>&1 ; cat sim.log \
  && grep -q "\*\*\* PASSED \*\*\*" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
rtl/snes_bus_pkg.sv
rtl/mem_pkg.sv
rtl/snes_slot_timer.sv
rtl/mem_config_regs.sv
rtl/mcu_request_router.sv
rtl/rom_arbiter.sv
rtl/ram_arbiter.sv
rtl/cart_mem_ctrl.sv
tests/tb_clock_gen.sv
tests/cart_mem_ctrl_checker.sv
tests/cart_mem_ctrl_tb.sv

// ==== tests/cart_mem_ctrl_checker.sv ====
`timescale 1ns/1ns
module cart_mem_ctrl_checker
  import mem_pkg::*;
(
  input logic       CLK2,
  input logic       SNES_reset_strobe,
  input logic       mcu_rdy,
  input logic       sa1_rom_rdy,
  input logic       sa1_ram_rdy,
  input rom_addr_t  rom_addr,
  input logic       rom_bhe,
  input logic       rom_ble,
  input ram_addr_t  ram_addr,
  input byte_t      ram_wdata,
  input logic       ram_we,
  input rom_state_e rom_state,
  input ram_state_e ram_state
);

  // all channels idle right after reset
  rdy_after_reset: assert property (@(posedge CLK2)
    $fell(SNES_reset_strobe) |-> (mcu_rdy && sa1_rom_rdy && sa1_ram_rdy))
    else $error("ready outputs not high after reset");

  // a read enables a byte lane and holds its address and lanes
  rom_lane_on_read: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    (rom_state == ROM_MCU_RD || rom_state == ROM_SA1_RD)
    |-> !(rom_bhe && rom_ble)
        && (rom_state != $past(rom_state) || $stable({rom_addr, rom_bhe, rom_ble})))
    else $error("ROM lanes off or address moving during a read");

  // the SRAM sees a steady address and byte for the whole write
  ram_we_only_on_write: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    !ram_we |-> (ram_state == RAM_MCU_WR || ram_state == RAM_SA1_WR)
                && ($past(ram_we) || $stable({ram_addr, ram_wdata})))
    else $error("ram_we active outside a RAM write state or write data moving");

endmodule

bind cart_mem_ctrl cart_mem_ctrl_checker u_chk (
  .CLK2,
  .SNES_reset_strobe,
  .mcu_rdy,
  .sa1_rom_rdy,
  .sa1_ram_rdy,
  .rom_addr,
  .rom_bhe,
  .rom_ble,
  .ram_addr,
  .ram_wdata,
  .ram_we,
  .rom_state(u_rom.state),
  .ram_state(u_ram.state)
);

// ==== tests/cart_mem_ctrl_tb.sv ====
`timescale 1ns/1ns
module cart_mem_ctrl_tb
  import snes_bus_pkg::*;
  import mem_pkg::*;
();

  logic       CLK2;
  logic       SNES_reset_strobe;
  logic       snes_cpu_clk;
  logic       is_rom;
  logic       is_saveram;
  snes_addr_t snes_addr;
  logic       mcu_rrq;
  logic       mcu_wrq;
  snes_addr_t mcu_addr;
  byte_t      mcu_wdata;
  logic       mcu_rdy;
  byte_t      mcu_rdata;
  logic       sa1_rom_rrq;
  snes_addr_t sa1_rom_addr;
  logic       sa1_rom_word;
  logic       sa1_rom_rdy;
  word_t      sa1_rom_rdata;
  logic       sa1_ram_rrq;
  logic       sa1_ram_wrq;
  snes_addr_t sa1_ram_addr;
  byte_t      sa1_ram_wdata;
  logic       sa1_ram_rdy;
  byte_t      sa1_ram_rdata;
  logic       cfg_we;
  byte_t      cfg_group;
  byte_t      cfg_index;
  byte_t      cfg_value;
  byte_t      cfg_invmask;
  rom_addr_t  rom_addr;
  word_t      rom_rdata;
  word_t      rom_wdata;
  logic       rom_we;
  logic       rom_bhe;
  logic       rom_ble;
  ram_addr_t  ram_addr;
  byte_t      ram_rdata;
  byte_t      ram_wdata;
  logic       ram_we;

  word_t       rom_mem [0:1023];
  byte_t       ram_mem [0:1023];
  logic [3:0]  pat_op [$];
  logic [23:0] pat_addr [$];
  logic [15:0] pat_wdata [$];
  logic [15:0] pat_expect [$];
  logic [3:0]  pat_flags [$];
  int          cycle_cnt;
  int          cycle_limit;
  int          error_cnt;
  logic [1:0]  div_cnt;
  int          since_fall;

  tb_clock_gen u_clk (
    .CLK2,
    .SNES_reset_strobe
  );

  cart_mem_ctrl dut0 (.*);

  // --------------------------------------------------
  // memory models
  // --------------------------------------------------
  initial begin
    for (int i = 0; i < 1024; i++) begin
      rom_mem[i] <= 16'(i * 40503 + 4660);
      ram_mem[i] <= 8'(i ^ (i >> 3) ^ 165);
    end
  end

  always_comb rom_rdata = rom_mem[rom_addr[9:0]];
  always_comb ram_rdata = ram_mem[ram_addr[9:0]];

  always @(posedge CLK2) begin
    if (!rom_we && !rom_bhe) rom_mem[rom_addr[9:0]][15:8] <= rom_wdata[15:8];
    if (!rom_we && !rom_ble) rom_mem[rom_addr[9:0]][7:0] <= rom_wdata[7:0];
    if (!ram_we) ram_mem[ram_addr[9:0]] <= ram_wdata;
  end

  // byte a finished MCU write left in the memory its bank selects
  function automatic logic [7:0] stored_byte(input logic [23:0] addr);
    if (addr[23:16] >= 8'hE0 && addr[23:16] <= 8'hE7) begin
      return ram_mem[addr[9:0]];
    end
    return addr[0] ? rom_mem[addr[10:1]][7:0] : rom_mem[addr[10:1]][15:8];
  endfunction

  // SNES CPU clock toggles every 4 cycles
  always @(posedge CLK2) begin
    div_cnt <= div_cnt + 2'd1;
    if (div_cnt == 2'd3) snes_cpu_clk <= !snes_cpu_clk;
    since_fall <= (div_cnt == 2'd3 && snes_cpu_clk) ? 0 : since_fall + 1;
  end

  // --------------------------------------------------
  // checks and timeout
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_cnt++;
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  always @(posedge CLK2) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("run stopped, no result within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  task automatic read_patterns();
    int    fd;
    int    n;
    string line;
    logic [3:0]  op;
    logic [23:0] addr;
    logic [15:0] wdata;
    logic [15:0] expect_v;
    logic [3:0]  flags;
    fd = $fopen("tests/mem_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file");
      $display("*** FAILED ***");
      $fatal(1);
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h", op, addr, wdata, expect_v, flags);
        if (n == 5) begin
          pat_op.push_back(op);
          pat_addr.push_back(addr);
          pat_wdata.push_back(wdata);
          pat_expect.push_back(expect_v);
          pat_flags.push_back(flags);
        end
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  task automatic mcu_request(input logic rd, input logic [23:0] addr, input logic [7:0] wd);
    @(posedge CLK2);
    mcu_rrq   <= rd;
    mcu_wrq   <= !rd;
    mcu_addr  <= addr;
    mcu_wdata <= wd;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
  endtask

  // counts the cycles mcu_rdy stays low
  task automatic wait_mcu_ready(output int busy);
    busy = 0;
    @(negedge CLK2);
    while (!mcu_rdy) begin
      busy++;
      @(negedge CLK2);
    end
  endtask

  task automatic sa1_rom_read(input logic [23:0] addr, input logic word);
    @(posedge CLK2);
    sa1_rom_rrq  <= 1'b1;
    sa1_rom_addr <= addr;
    sa1_rom_word <= word;
    @(posedge CLK2);
    sa1_rom_rrq <= 1'b0;
    @(negedge CLK2);
    while (!sa1_rom_rdy) @(negedge CLK2);
  endtask

  task automatic sa1_ram_access(input logic rd, input logic [23:0] addr,
                                input logic [7:0] wd);
    @(posedge CLK2);
    sa1_ram_rrq   <= rd;
    sa1_ram_wrq   <= !rd;
    sa1_ram_addr  <= addr;
    sa1_ram_wdata <= wd;
    @(posedge CLK2);
    sa1_ram_rrq <= 1'b0;
    sa1_ram_wrq <= 1'b0;
    @(negedge CLK2);
    while (!sa1_ram_rdy) @(negedge CLK2);
  endtask

  // SA1 write and MCU read to the same save RAM byte in one cycle
  task automatic sa1_then_mcu(input string name, input logic [23:0] addr,
                              input logic [7:0] wd);
    int t;
    int sa1_t;
    int mcu_t;
    t = 0;
    sa1_t = -1;
    mcu_t = -1;
    @(posedge CLK2);
    sa1_ram_wrq   <= 1'b1;
    sa1_ram_addr  <= addr;
    sa1_ram_wdata <= wd;
    mcu_rrq       <= 1'b1;
    mcu_addr      <= addr;
    @(posedge CLK2);
    sa1_ram_wrq <= 1'b0;
    mcu_rrq     <= 1'b0;
    @(negedge CLK2);
    while (sa1_t < 0 || mcu_t < 0) begin
      t++;
      if (sa1_ram_rdy && sa1_t < 0) sa1_t = t;
      if (mcu_rdy && mcu_t < 0) mcu_t = t;
      @(negedge CLK2);
    end
    check_value({name, " sa1 first"}, 32'd1, 32'(sa1_t < mcu_t));
  endtask

  // ROM read with the SNES on the ROM waits for a cycle end
  task automatic slotted_read(input string name, input logic [23:0] addr);
    logic granted;
    granted = 1'b0;
    mcu_request(1'b1, addr, 8'h00);
    @(negedge CLK2);
    while (!mcu_rdy) begin
      if (!granted && rom_addr != snes_addr[23:1]) begin
        granted = 1'b1;
        check_value({name, " grant slot"}, 32'd1, 32'(since_fall >= 3 && since_fall <= 5));
      end
      @(negedge CLK2);
    end
    check_value({name, " granted"}, 32'd1, 32'(granted));
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    string      tname;
    int         busy;
    logic [3:0] op;
    logic [23:0] addr;
    logic [15:0] wd;
    logic [15:0] ex;
    cycle_cnt     = 0;
    cycle_limit   = 1000;
    error_cnt     = 0;
    div_cnt       = 2'd0;
    since_fall    = 100;
    snes_cpu_clk  = 1'b1;
    is_rom        = 1'b0;
    is_saveram    = 1'b0;
    snes_addr     = '0;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    sa1_rom_rrq   = 1'b0;
    sa1_rom_addr  = '0;
    sa1_rom_word  = 1'b0;
    sa1_ram_rrq   = 1'b0;
    sa1_ram_wrq   = 1'b0;
    sa1_ram_addr  = '0;
    sa1_ram_wdata = '0;
    cfg_we        = 1'b0;
    cfg_group     = '0;
    cfg_index     = '0;
    cfg_value     = '0;
    cfg_invmask   = '0;
    read_patterns();
    cycle_limit = pat_op.size() * 64 + 100;
    @(negedge SNES_reset_strobe);
    repeat (2) @(posedge CLK2);
    foreach (pat_op[i]) begin
      op    = pat_op[i];
      addr  = pat_addr[i];
      wd    = pat_wdata[i];
      ex    = pat_expect[i];
      tname = $sformatf("line %0d op %0h", i, op);
      @(posedge CLK2);
      is_rom     <= pat_flags[i][0];
      is_saveram <= pat_flags[i][1];
      snes_addr  <= (op == 4'h0) ? addr : ~addr;
      case (op)
        4'h0: begin
          @(negedge CLK2);
          check_value({tname, " rom_addr"}, 32'(addr[23:1]), 32'(rom_addr));
          check_value({tname, " ram_addr"}, 32'(addr[18:0]), 32'(ram_addr));
          check_value({tname, " rdy"}, 32'h7, 32'({mcu_rdy, sa1_rom_rdy, sa1_ram_rdy}));
          check_value({tname, " we"}, 32'h3, 32'({rom_we, ram_we}));
        end
        4'h1: begin
          mcu_request(1'b0, addr, wd[7:0]);
          wait_mcu_ready(busy);
          check_value({tname, " stored"}, 32'(wd[7:0]), 32'(stored_byte(addr)));
        end
        4'h2: begin
          mcu_request(1'b1, addr, 8'h00);
          wait_mcu_ready(busy);
          check_value(tname, 32'(ex[7:0]), 32'(mcu_rdata));
        end
        4'h3, 4'h4: begin
          sa1_rom_read(addr, op == 4'h4);
          check_value(tname, 32'(ex), 32'(sa1_rom_rdata));
        end
        4'h5: sa1_ram_access(1'b0, addr, wd[7:0]);
        4'h6: begin
          sa1_ram_access(1'b1, addr, 8'h00);
          check_value(tname, 32'(ex[7:0]), 32'(sa1_ram_rdata));
        end
        4'h7: begin
          sa1_then_mcu(tname, addr, wd[7:0]);
          check_value(tname, 32'(ex[7:0]), 32'(mcu_rdata));
        end
        4'h8: begin
          cfg_we      <= 1'b1;
          cfg_group   <= CFG_GROUP_MEM;
          cfg_index   <= CFG_IDX_ROM_LEN;
          cfg_value   <= wd[7:0];
          cfg_invmask <= addr[7:0];
          @(posedge CLK2);
          cfg_we <= 1'b0;
        end
        4'h9: begin
          mcu_request(1'b1, addr, 8'h00);
          wait_mcu_ready(busy);
          check_value({tname, " busy cycles"}, 32'(ex), 32'(busy));
        end
        4'hA: begin
          slotted_read(tname, addr);
          check_value(tname, 32'(ex[7:0]), 32'(mcu_rdata));
        end
        default: begin
          $display("unknown operation code %0h on pattern line %0d", op, i);
          $display("*** FAILED ***");
          $fatal(1);
        end
      endcase
    end
    repeat (2) @(posedge CLK2);
    if (error_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tests/mem_patterns.txt ====
# op addr wdata expect flags(bit0 is_rom, bit1 is_saveram), all hex
# op 0 idle, 1/2 MCU wr/rd, 3/4 SA1 ROM byte/word, 5/6 SA1 RAM wr/rd
# op 7 SA1 RAM wr with MCU rd, 8 ROM length cfg (addr = invmask), 9 MCU busy time
# op A MCU ROM read with the SNES on the ROM
0 123456 0000 0000 0
0 FEDCBA 0000 0000 0
1 000100 00AB 0000 0
1 000101 00CD 0000 0
2 000100 0000 00AB 0
2 000101 0000 00CD 0
1 E00010 005A 0000 0
2 E00010 0000 005A 0
2 000100 0000 00AB 0
4 000101 0000 ABCD 0
4 000100 0000 CDAB 0
3 000100 0000 CDAB 0
5 000020 0077 0000 0
6 000020 0000 0077 0
7 E00030 0099 0099 0
9 000101 0000 000A 0
8 0000F8 0003 0000 0
9 000101 0000 0006 0
A 000100 0000 00AB 1
A 000101 0000 00CD 1
2 E00010 0000 005A 0

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns
module tb_clock_gen (
  output logic CLK2,
  output logic SNES_reset_strobe
);

  // 100 ns period
  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = !CLK2;
  end

  initial begin
    SNES_reset_strobe = 1'b1;
    repeat (2) @(posedge CLK2);
    SNES_reset_strobe <= 1'b0;
  end

endmodule
